//--- all.f
+incdir+bench
logic/harness_pkg.sv
logic/reset_sync.sv
logic/debug_delay_timer.sv
logic/debug_source_sel.sv
logic/addr_decoder.sv
logic/exit_fsm.sv
logic/harness_top.sv
bench/harness_tb.sv

//--- bench/harness_checks.svh
// Compare tasks included inside harness_tb; they update its chk_cnt and err_cnt counters
`ifndef HARNESS_CHECKS_SVH
`define HARNESS_CHECKS_SVH

task automatic check_bit(input string name, input logic exp, input logic act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
  end
endtask

task automatic check_dmi_side(input string name, input harness_pkg::dmi_side_t exp,
                              input harness_pkg::dmi_side_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
  end
endtask

task automatic check_slave_sel(input string name, input harness_pkg::slave_sel_t exp,
                               input harness_pkg::slave_sel_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
  end
endtask

task automatic check_exit(input string name, input harness_pkg::exit_word_u exp,
                          input harness_pkg::exit_word_u act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("ERROR %0t %s expected %h actual %h", $time, name, exp.raw, act.raw);
  end
endtask

`endif

//--- bench/harness_tb.sv
// Table-driven bench for harness_top; inputs change 10 ns after each rising edge of a 100 ns clock
`timescale 1ns/1ps

module harness_tb;

  localparam int unsigned RST_CYCLES = 10;
  // Reset, boot delay and two exit waits, doubled for the tables and margin
  localparam int unsigned MAX_CYCLES = 2 * (RST_CYCLES + harness_pkg::DMI_DELAY_CYCLES +
                                      2 * (harness_pkg::TANDEM_TIMEOUT_CYCLES + 1) + 64);
  localparam int unsigned EXIT_LIMIT = harness_pkg::TANDEM_TIMEOUT_CYCLES + 1;

  typedef struct packed {
    logic en;
    logic req;
    logic exp;
  } gate_row_t;

  typedef struct packed {
    harness_pkg::dmi_side_t jtag;
    harness_pkg::dmi_side_t dtm;
  } sel_row_t;

  typedef struct packed {
    logic [harness_pkg::ADDR_W-1:0] base;
    logic [harness_pkg::ADDR_W-1:0] len;
    harness_pkg::slave_idx_e        idx;
  } region_row_t;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           ndmreset_i;
  logic                           jtag_enable_i;
  logic                           debug_enable_i;
  harness_pkg::dmi_side_t         jtag_side_i;
  harness_pkg::dmi_side_t         dtm_side_i;
  logic                           dm_resp_valid_i;
  logic                           dm_debug_req_i;
  logic [harness_pkg::ADDR_W-1:0] bus_addr_i;
  harness_pkg::exit_word_u        tracer_exit_i;
  harness_pkg::exit_word_u        tandem_exit_i;
  harness_pkg::exit_word_u        jtag_exit_i;
  logic                           core_rst_no;
  logic                           core_debug_req_o;
  harness_pkg::dmi_side_t         dm_side_o;
  logic                           jtag_resp_valid_o;
  logic                           dtm_resp_valid_o;
  harness_pkg::slave_sel_t        slave_sel_o;
  harness_pkg::exit_word_u        exit_o;

  int unsigned err_cnt = 0;
  int unsigned chk_cnt = 0;
  int unsigned edges   = 0;
  int unsigned cycles  = 0;

  `include "harness_checks.svh"

  // en, req, expected request
  gate_row_t gate_tab [4] = '{3'b000, 3'b010, 3'b100, 3'b111};

  region_row_t region_tab [6] = '{
    '{64'h0000_0000, 64'h0000_1000, harness_pkg::SLV_DEBUG},
    '{64'h0001_0000, 64'h0001_0000, harness_pkg::SLV_ROM},
    '{64'h0200_0000, 64'h000C_0000, harness_pkg::SLV_CLINT},
    '{64'h1000_0000, 64'h0000_1000, harness_pkg::SLV_UART},
    '{64'h4000_0000, 64'h0000_1000, harness_pkg::SLV_GPIO},
    '{64'h8000_0000, 64'h4000_0000, harness_pkg::SLV_DRAM}
  };

  // Unmapped holes between and above the regions
  logic [harness_pkg::ADDR_W-1:0] gap_tab [2] = '{64'h0000_8000, 64'h1_0000_0000};

  sel_row_t sel_tab [3];

  harness_top dut_i (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Run stopped after %0d cycles before all tests finished", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic harness_pkg::dmi_side_t make_side(input logic [6:0] addr,
      input harness_pkg::dmi_op_e op, input logic [31:0] data, input logic valid,
      input logic ready);
    harness_pkg::dmi_side_t s;
    s.req.addr   = addr;
    s.req.op     = op;
    s.req.data   = data;
    s.req_valid  = valid;
    s.resp_ready = ready;
    return s;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #10;
    edges++;
  endtask

  // Outputs are read 10 ns before the next edge
  task automatic sample();
    #80;
  endtask

  task automatic wait_exit_done(input int unsigned limit);
    int unsigned n;
    n = 0;
    sample();
    while (exit_o.f.done !== 1'b1 && n < limit) begin
      next_cycle();
      sample();
      n++;
    end
    if (exit_o.f.done !== 1'b1) begin
      err_cnt++;
      $display("Exit word did not report done within %0d cycles", limit);
    end
  endtask

  initial begin
    harness_pkg::exit_word_u word;
    harness_pkg::slave_sel_t exp_sel;
    harness_pkg::dmi_side_t  exp_side;
    logic                    sel_jtag;
    logic                    resp;

    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    ndmreset_i      = 1'b0;
    jtag_enable_i   = 1'b0;
    debug_enable_i  = 1'b1;
    dm_debug_req_i  = 1'b1;
    jtag_side_i     = '0;
    dtm_side_i      = '0;
    dm_resp_valid_i = 1'b0;
    bus_addr_i      = '0;
    tracer_exit_i   = '0;
    tandem_exit_i   = '0;
    jtag_exit_i     = '0;

    sel_tab[0] = '{make_side(7'h10, harness_pkg::DMI_READ, 32'h1111_0000, 1'b1, 1'b0),
                   make_side(7'h11, harness_pkg::DMI_WRITE, 32'h2222_0000, 1'b0, 1'b1)};
    sel_tab[1] = '{make_side(7'h7F, harness_pkg::DMI_WRITE, 32'hDEAD_BEEF, 1'b1, 1'b1),
                   make_side(7'h01, harness_pkg::DMI_NOP, 32'h0000_0001, 1'b1, 1'b0)};
    sel_tab[2] = '{make_side(7'h00, harness_pkg::DMI_NOP, 32'h0000_0000, 1'b0, 1'b0),
                   make_side(7'h40, harness_pkg::DMI_READ, 32'hFFFF_FFFF, 1'b1, 1'b1)};

    // ----------------------------------------
    // Reset and ndmreset
    // ----------------------------------------
    repeat (RST_CYCLES) begin
      @(posedge clk_i);
      #90;
      check_bit("core_rst_no", 1'b0, core_rst_no);
    end
    next_cycle();
    rst_ni = 1'b1;
    edges  = 0;
    sample();
    check_bit("core_rst_no", 1'b0, core_rst_no);
    next_cycle();
    sample();
    check_bit("core_rst_no", 1'b0, core_rst_no);
    next_cycle();
    sample();
    check_bit("core_rst_no", 1'b1, core_rst_no);

    next_cycle();
    ndmreset_i = 1'b1;
    sample();
    check_bit("core_rst_no", 1'b1, core_rst_no);
    next_cycle();
    ndmreset_i = 1'b0;
    sample();
    check_bit("core_rst_no", 1'b0, core_rst_no);
    next_cycle();
    sample();
    check_bit("core_rst_no", 1'b0, core_rst_no);
    next_cycle();
    sample();
    check_bit("core_rst_no", 1'b1, core_rst_no);

    // ----------------------------------------
    // Debug request hold-off
    // ----------------------------------------
    while (edges < harness_pkg::DMI_DELAY_CYCLES) begin
      check_bit("core_debug_req_o", 1'b0, core_debug_req_o);
      next_cycle();
      sample();
    end
    check_bit("core_debug_req_o", 1'b1, core_debug_req_o);

    foreach (gate_tab[i]) begin
      next_cycle();
      debug_enable_i = gate_tab[i].en;
      dm_debug_req_i = gate_tab[i].req;
      sample();
      check_bit("core_debug_req_o", gate_tab[i].exp, core_debug_req_o);
    end

    // ----------------------------------------
    // DMI source select
    // ----------------------------------------
    foreach (sel_tab[i]) begin
      for (int k = 0; k < 4; k++) begin
        sel_jtag = k[1];
        resp     = k[0];
        next_cycle();
        jtag_side_i     = sel_tab[i].jtag;
        dtm_side_i      = sel_tab[i].dtm;
        jtag_enable_i   = sel_jtag;
        dm_resp_valid_i = resp;
        sample();
        exp_side = sel_jtag ? sel_tab[i].jtag : sel_tab[i].dtm;
        check_dmi_side("dm_side_o", exp_side, dm_side_o);
        check_bit("jtag_resp_valid_o", sel_jtag & resp, jtag_resp_valid_o);
        check_bit("dtm_resp_valid_o", ~sel_jtag & resp, dtm_resp_valid_o);
      end
    end
    jtag_enable_i   = 1'b0;
    dm_resp_valid_i = 1'b0;

    // ----------------------------------------
    // Address map: base, last byte, first byte past
    // ----------------------------------------
    foreach (region_tab[i]) begin
      for (int p = 0; p < 3; p++) begin
        next_cycle();
        bus_addr_i  = region_tab[i].base + (p == 0 ? 64'd0 :
                      (p == 1 ? region_tab[i].len - 64'd1 : region_tab[i].len));
        exp_sel.hit = (p < 2);
        exp_sel.idx = (p < 2) ? region_tab[i].idx : harness_pkg::SLV_DEBUG;
        sample();
        check_slave_sel("slave_sel_o", exp_sel, slave_sel_o);
      end
    end
    foreach (gap_tab[i]) begin
      next_cycle();
      bus_addr_i  = gap_tab[i];
      exp_sel.hit = 1'b0;
      exp_sel.idx = harness_pkg::SLV_DEBUG;
      sample();
      check_slave_sel("slave_sel_o", exp_sel, slave_sel_o);
    end

    // ----------------------------------------
    // Exit reporting, tandem done arrives
    // ----------------------------------------
    word.raw = 32'hC0DE_0A51;
    next_cycle();
    tracer_exit_i = word;
    sample();
    check_exit("exit_o", '0, exit_o);
    next_cycle();
    tracer_exit_i = '0;
    repeat (3) begin
      sample();
      check_exit("exit_o", '0, exit_o);
      next_cycle();
    end
    // Release on the first edge that sees tandem done
    tandem_exit_i.raw = 32'h0000_0001;
    sample();
    check_exit("exit_o", '0, exit_o);
    next_cycle();
    sample();
    check_exit("exit_o", word, exit_o);

    // Second run, tandem done withheld
    next_cycle();
    rst_ni        = 1'b0;
    tandem_exit_i = '0;
    repeat (2) next_cycle();
    rst_ni = 1'b1;
    sample();
    check_exit("exit_o", '0, exit_o);
    word.raw = 32'h0BAD_F00D;
    next_cycle();
    tracer_exit_i = word;
    next_cycle();
    tracer_exit_i = '0;
    wait_exit_done(EXIT_LIMIT);
    check_exit("exit_o", word, exit_o);

    next_cycle();
    jtag_enable_i   = 1'b1;
    jtag_exit_i.raw = 32'h5EED_0003;
    sample();
    check_exit("exit_o", jtag_exit_i, exit_o);

    $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- logic/addr_decoder.sv
// Address map lookup with half-open ranges; an unmapped address gives hit low and index zero
`timescale 1ns/1ps

module addr_decoder (
  input  logic [harness_pkg::ADDR_W-1:0] addr_i,
  output harness_pkg::slave_sel_t        slave_sel_o
);

  logic [harness_pkg::NR_SLAVES-1:0] match;

  // One range compare per region
  for (genvar i = 0; i < harness_pkg::NR_SLAVES; i++) begin : g_match
    assign match[i] = (addr_i >= harness_pkg::REGION_BASE[i]) &&
                      (addr_i < harness_pkg::REGION_BASE[i] + harness_pkg::REGION_LEN[i]);
  end

  always_comb begin
    slave_sel_o.hit = 1'b0;
    slave_sel_o.idx = harness_pkg::SLV_DEBUG;
    for (int i = 0; i < harness_pkg::NR_SLAVES; i++) begin
      if (match[i]) begin
        slave_sel_o.hit = 1'b1;
        slave_sel_o.idx = harness_pkg::slave_idx_e'(i);
      end
    end
  end

  // Overlapping regions in the map would show up here
  always_comb begin : p_map_check
    a_single_match: assert final ($onehot0(match))
      else $error("address %h hits more than one region", addr_i);
  end

endmodule

//--- logic/debug_delay_timer.sv
// Debug request blocked for DMI_DELAY_CYCLES edges after rst_ni release, then gated by enable
`timescale 1ns/1ps

module debug_delay_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dm_debug_req_i,
  input  logic debug_enable_i,
  output logic core_debug_req_o
);

  harness_pkg::delay_cnt_t cnt_q;
  logic                    expired;

  // Boot window countdown, saturates at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= harness_pkg::DMI_DELAY_LOAD;
    end else if (!expired) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign expired = (cnt_q == '0);

  assign core_debug_req_o = expired & debug_enable_i & dm_debug_req_i;

  // Window must not reopen once counting has started
  a_cnt_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= $past(cnt_q)
  ) else $error("debug delay counter went up outside reset");

endmodule

//--- logic/debug_source_sel.sv
// JTAG/DTM debug source select; jtag_enable_i is a static level, no switching mid-transfer
`timescale 1ns/1ps

module debug_source_sel (
  input  logic                   jtag_enable_i,
  input  harness_pkg::dmi_side_t jtag_side_i,
  input  harness_pkg::dmi_side_t dtm_side_i,
  input  logic                   dm_resp_valid_i,
  output harness_pkg::dmi_side_t dm_side_o,
  output logic                   jtag_resp_valid_o,
  output logic                   dtm_resp_valid_o,

  input  harness_pkg::exit_word_u jtag_exit_i,
  input  harness_pkg::exit_word_u rvfi_exit_i,
  output harness_pkg::exit_word_u exit_o
);

  // ----------------------------------------
  // Request path to the debug module
  // ----------------------------------------
  assign dm_side_o = jtag_enable_i ? jtag_side_i : dtm_side_i;

  // Response strobe back to the active source only
  assign jtag_resp_valid_o = jtag_enable_i & dm_resp_valid_i;
  assign dtm_resp_valid_o  = ~jtag_enable_i & dm_resp_valid_i;

  // ----------------------------------------
  // End-of-test word
  // ----------------------------------------
  assign exit_o = jtag_enable_i ? jtag_exit_i : rvfi_exit_i;

endmodule

//--- logic/exit_fsm.sv
// End-of-test report; waits for tandem done at most TANDEM_TIMEOUT_CYCLES after tracer done
`timescale 1ns/1ps

module exit_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  harness_pkg::exit_word_u tracer_exit_i,
  input  harness_pkg::exit_word_u tandem_exit_i,
  output harness_pkg::exit_word_u rvfi_exit_o
);

  typedef enum logic [1:0] {
    ST_RUN,
    ST_WAIT,
    ST_DONE
  } state_e;

  state_e                  state_q;
  state_e                  state_d;
  harness_pkg::wait_cnt_t  cnt_q;
  harness_pkg::exit_word_u word_q;
  logic                    release_now;

  assign release_now = tandem_exit_i.f.done || (cnt_q == harness_pkg::TANDEM_TIMEOUT_MAX);

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RUN: begin
        if (tracer_exit_i.f.done) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (release_now) begin
          state_d = ST_DONE;
        end
      end
      default: state_d = ST_DONE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_RUN;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // Count only while waiting on the reference model
      if (state_q == ST_WAIT && !release_now) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Tracer word captured on its first done
  always_ff @(posedge clk_i) begin
    if (state_q == ST_RUN && tracer_exit_i.f.done) begin
      word_q <= tracer_exit_i;
    end
  end

  assign rvfi_exit_o = (state_q == ST_DONE) ? word_q : '0;

  a_done_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q == ST_DONE |=> state_q == ST_DONE
  ) else $error("exit state machine left done without reset");

  a_cnt_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= harness_pkg::TANDEM_TIMEOUT_MAX
  ) else $error("tandem wait counter past its limit");

endmodule

//--- logic/harness_pkg.sv
// Shared types and constants for the harness shell; the address map assumes non-overlapping regions
package harness_pkg;

  // ----------------------------------------
  // Widths and timing
  // ----------------------------------------
  localparam int unsigned DMI_ADDR_W            = 7;
  localparam int unsigned DMI_DATA_W            = 32;
  localparam int unsigned ADDR_W                = 64;
  localparam int unsigned EXIT_W                = 32;
  localparam int unsigned DMI_DELAY_CYCLES      = 500;
  localparam int unsigned TANDEM_TIMEOUT_CYCLES = 60;
  localparam int unsigned SYNC_STAGES           = 2;
  localparam int unsigned NR_SLAVES             = 6;

  localparam int unsigned DMI_DELAY_W = $clog2(DMI_DELAY_CYCLES + 1);
  localparam int unsigned WAIT_CNT_W  = $clog2(TANDEM_TIMEOUT_CYCLES + 1);

  typedef logic [DMI_DELAY_W-1:0] delay_cnt_t;
  typedef logic [WAIT_CNT_W-1:0]  wait_cnt_t;

  localparam delay_cnt_t DMI_DELAY_LOAD     = delay_cnt_t'(DMI_DELAY_CYCLES);
  localparam wait_cnt_t  TANDEM_TIMEOUT_MAX = wait_cnt_t'(TANDEM_TIMEOUT_CYCLES);

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam logic [ADDR_W-1:0] DEBUG_BASE = 64'h0000_0000;
  localparam logic [ADDR_W-1:0] DEBUG_LEN  = 64'h0000_1000;
  localparam logic [ADDR_W-1:0] ROM_BASE   = 64'h0001_0000;
  localparam logic [ADDR_W-1:0] ROM_LEN    = 64'h0001_0000;
  localparam logic [ADDR_W-1:0] CLINT_BASE = 64'h0200_0000;
  localparam logic [ADDR_W-1:0] CLINT_LEN  = 64'h000C_0000;
  localparam logic [ADDR_W-1:0] UART_BASE  = 64'h1000_0000;
  localparam logic [ADDR_W-1:0] UART_LEN   = 64'h0000_1000;
  localparam logic [ADDR_W-1:0] GPIO_BASE  = 64'h4000_0000;
  localparam logic [ADDR_W-1:0] GPIO_LEN   = 64'h0000_1000;
  localparam logic [ADDR_W-1:0] DRAM_BASE  = 64'h8000_0000;
  localparam logic [ADDR_W-1:0] DRAM_LEN   = 64'h4000_0000;

  // Index 0 is DEBUG, same order as slave_idx_e
  localparam logic [NR_SLAVES-1:0][ADDR_W-1:0] REGION_BASE = {
    DRAM_BASE, GPIO_BASE, UART_BASE, CLINT_BASE, ROM_BASE, DEBUG_BASE
  };
  localparam logic [NR_SLAVES-1:0][ADDR_W-1:0] REGION_LEN = {
    DRAM_LEN, GPIO_LEN, UART_LEN, CLINT_LEN, ROM_LEN, DEBUG_LEN
  };

  typedef enum logic [2:0] {
    SLV_DEBUG,
    SLV_ROM,
    SLV_CLINT,
    SLV_UART,
    SLV_GPIO,
    SLV_DRAM
  } slave_idx_e;

  typedef struct packed {
    logic       hit;
    slave_idx_e idx;
  } slave_sel_t;

  // ----------------------------------------
  // Debug module interface
  // ----------------------------------------
  typedef enum logic [1:0] {
    DMI_NOP   = 2'h0,
    DMI_READ  = 2'h1,
    DMI_WRITE = 2'h2
  } dmi_op_e;

  typedef struct packed {
    logic [DMI_ADDR_W-1:0] addr;
    dmi_op_e               op;
    logic [DMI_DATA_W-1:0] data;
  } dmi_req_t;

  // Outgoing bundle of one debug source
  typedef struct packed {
    dmi_req_t req;
    logic     req_valid;
    logic     resp_ready;
  } dmi_side_t;

  // End-of-test word, bit 0 flags completion
  typedef struct packed {
    logic [EXIT_W-2:0] code;
    logic              done;
  } exit_fields_t;

  typedef union packed {
    logic [EXIT_W-1:0] raw;
    exit_fields_t      f;
  } exit_word_u;

endpackage

//--- logic/harness_top.sv
// Harness control shell on one clock; core, memories and the debug module sit outside
`timescale 1ns/1ps

module harness_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          ndmreset_i,
  input  logic                          jtag_enable_i,
  input  logic                          debug_enable_i,
  input  harness_pkg::dmi_side_t        jtag_side_i,
  input  harness_pkg::dmi_side_t        dtm_side_i,
  input  logic                          dm_resp_valid_i,
  input  logic                          dm_debug_req_i,
  input  logic [harness_pkg::ADDR_W-1:0] bus_addr_i,
  input  harness_pkg::exit_word_u       tracer_exit_i,
  input  harness_pkg::exit_word_u       tandem_exit_i,
  input  harness_pkg::exit_word_u       jtag_exit_i,
  output logic                          core_rst_no,
  output logic                          core_debug_req_o,
  output harness_pkg::dmi_side_t        dm_side_o,
  output logic                          jtag_resp_valid_o,
  output logic                          dtm_resp_valid_o,
  output harness_pkg::slave_sel_t       slave_sel_o,
  output harness_pkg::exit_word_u       exit_o
);

  harness_pkg::exit_word_u rvfi_exit;

  // ----------------------------------------
  // Reset and debug request
  // ----------------------------------------
  reset_sync i_reset_sync (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .core_rst_no ( core_rst_no )
  );

  debug_delay_timer i_debug_delay_timer (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .dm_debug_req_i   ( dm_debug_req_i   ),
    .debug_enable_i   ( debug_enable_i   ),
    .core_debug_req_o ( core_debug_req_o )
  );

  debug_source_sel i_debug_source_sel (
    .jtag_enable_i     ( jtag_enable_i     ),
    .jtag_side_i       ( jtag_side_i       ),
    .dtm_side_i        ( dtm_side_i        ),
    .dm_resp_valid_i   ( dm_resp_valid_i   ),
    .dm_side_o         ( dm_side_o         ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .jtag_exit_i       ( jtag_exit_i       ),
    .rvfi_exit_i       ( rvfi_exit         ),
    .exit_o            ( exit_o            )
  );

  addr_decoder i_addr_decoder (
    .addr_i      ( bus_addr_i  ),
    .slave_sel_o ( slave_sel_o )
  );

  exit_fsm i_exit_fsm (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .tracer_exit_i ( tracer_exit_i ),
    .tandem_exit_i ( tandem_exit_i ),
    .rvfi_exit_o   ( rvfi_exit     )
  );

endmodule

//--- logic/reset_sync.sv
// Core reset from harness reset and ndmreset; release takes SYNC_STAGES clock edges
`timescale 1ns/1ps

module reset_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic core_rst_no
);

  logic [harness_pkg::SYNC_STAGES-1:0] sync_q;

  // Ones shift in once both resets are gone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= '0;
    end else if (ndmreset_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[harness_pkg::SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign core_rst_no = sync_q[harness_pkg::SYNC_STAGES-1];

  // ndmreset must hold the core in reset on the following cycle
  a_ndmreset_holds: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $past(ndmreset_i) |-> !core_rst_no
  ) else $error("core reset released right after ndmreset");

endmodule
